// File: rtl/spi_pkg.sv
package spi_pkg;

	// --------------------------------------------------------------------------
	// register map
	// --------------------------------------------------------------------------

	// address 3 is unmapped and reads as zero.
	typedef enum logic [1:0] {
		SPI_CTRL = 2'd0,    // control.
		SPI_STAT = 2'd1,    // status, read only.
		SPI_DATA = 2'd2     // tx buffer on write, rx buffer on read.
	} spi_addr_e;

	// control register, msb first.
	typedef struct packed {
		logic       en;     // block enable, low aborts a transfer.
		logic       cpol;   // sck idle level.
		logic       cpha;   // sample on trailing edge when set.
		logic       ie;     // irq on rxne.
		logic       spare;
		logic [2:0] div;    // tick every 2^(div+1) clocks.
	} spi_ctrl_t;

	// status register.
	typedef struct packed {
		logic       txe;    // tx buffer empty.
		logic       rxne;   // rx buffer holds an unread word.
		logic       busy;   // shift engine active.
		logic [4:0] zero;
	} spi_stat_t;

	// --------------------------------------------------------------------------
	// bus strobes
	// --------------------------------------------------------------------------

	// data travels beside this struct, its width is a module parameter.
	typedef struct packed {
		logic      wr;
		logic      rd;
		spi_addr_e addr;
	} spi_bus_t;

	// --------------------------------------------------------------------------
	// shift engine
	// --------------------------------------------------------------------------

	typedef enum logic [1:0] {
		SH_IDLE  = 2'd0,    // waiting for a word.
		SH_LEAD  = 2'd1,    // sck at cpol, next tick is the leading edge.
		SH_TRAIL = 2'd2     // sck active, next tick is the trailing edge.
	} spi_shift_state_e;

endpackage

// File: rtl/spi_regs.sv
`timescale 1ns/1ps

module spi_regs #(
	parameter int DATA_W = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  spi_pkg::spi_bus_t  bus,
	input  logic [DATA_W-1:0]  wdata,
	input  logic               tx_take,
	input  logic               rx_done,
	input  logic [DATA_W-1:0]  rx_word,
	input  logic               busy,
	output logic [DATA_W-1:0]  rdata,
	output spi_pkg::spi_ctrl_t ctrl,
	output logic [DATA_W-1:0]  tx_word,
	output logic               tx_valid,
	output logic               irq
);

	logic               txe;
	logic               rxne;
	logic [DATA_W-1:0]  rx_buf;
	logic               wr_ctrl;
	logic               wr_data;
	logic               rd_data;
	spi_pkg::spi_stat_t stat;

	// --------------------------------------------------------------------------
	// strobe decode
	// --------------------------------------------------------------------------

	assign wr_ctrl = bus.wr && (bus.addr == spi_pkg::SPI_CTRL);
	assign wr_data = bus.wr && (bus.addr == spi_pkg::SPI_DATA);
	assign rd_data = bus.rd && (bus.addr == spi_pkg::SPI_DATA);   // pops rxne.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (wr_ctrl) begin
			ctrl <= wdata[7:0];   // control fits the low byte.
		end
	end

	// --------------------------------------------------------------------------
	// flags and buffers
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			txe  <= 1'b1;
			rxne <= 1'b0;
		end else if (!ctrl.en) begin
			txe  <= 1'b1;
			rxne <= 1'b0;
		end else begin
			// a new write wins over a take at the same edge.
			if (wr_data)
				txe <= 1'b0;
			else if (tx_take)
				txe <= 1'b1;
			// fresh data wins over a read.
			if (rx_done)
				rxne <= 1'b1;
			else if (rd_data)
				rxne <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!ctrl.en) begin
			tx_word <= '0;
			rx_buf  <= '0;
		end else begin
			if (wr_data)
				tx_word <= wdata;   // overwrites a queued word.
			if (rx_done)
				rx_buf <= rx_word;  // unread word is lost.
		end
	end

	assign tx_valid = !txe;

	// --------------------------------------------------------------------------
	// read mux and irq
	// --------------------------------------------------------------------------

	always_comb begin
		stat      = '0;
		stat.txe  = txe;
		stat.rxne = rxne;
		stat.busy = busy;
	end

	always_comb begin
		rdata = '0;
		if (bus.rd) begin
			case (bus.addr)
				spi_pkg::SPI_CTRL: rdata[7:0] = ctrl;
				spi_pkg::SPI_STAT: rdata[7:0] = stat;
				spi_pkg::SPI_DATA: rdata = rx_buf;
				default:           rdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq <= 1'b0;
		else
			irq <= rxne && ctrl.ie;
	end

	// the shift engine only loads a word the buffer really holds.
	a_take_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n) tx_take |-> tx_valid);

endmodule

// File: rtl/spi_clkgen.sv
`timescale 1ns/1ps

module spi_clkgen #(
	parameter int DIV_W = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  spi_pkg::spi_ctrl_t ctrl,
	input  logic               run,
	output logic               tick
);

	logic [DIV_W-1:0] cnt;
	logic [DIV_W:0]   span;   // one bit wider, div=7 on an 8 bit counter.
	logic [DIV_W-1:0] mask;

	// --------------------------------------------------------------------------
	// prescaler counter
	// --------------------------------------------------------------------------

	// restarts from zero whenever the shift engine is idle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt <= '0;
		else if (!run)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// --------------------------------------------------------------------------
	// tick decode
	// --------------------------------------------------------------------------

	// low div+1 bits.
	always_comb begin
		span = ({{DIV_W{1'b0}}, 1'b1} << ({1'b0, ctrl.div} + 4'd1)) - 1'b1;
		mask = span[DIV_W-1:0];
	end

	// all ones below bit div+1 means that bit flips on the next count,
	// one pulse per half period of sck.
	assign tick = run && ((cnt & mask) == mask);

	// half periods never run together.
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rst_n) tick |=> !tick);

endmodule

// File: rtl/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
	parameter int DATA_W = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  spi_pkg::spi_ctrl_t ctrl,
	input  logic               tick,
	input  logic [DATA_W-1:0]  tx_word,
	input  logic               tx_valid,
	input  logic               miso,
	output logic               run,
	output logic               tx_take,
	output logic [DATA_W-1:0]  rx_word,
	output logic               rx_done,
	output logic               busy,
	output logic               sck,
	output logic               mosi
);

	localparam int               CNT_W    = $clog2(DATA_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_W - 1);

	spi_pkg::spi_shift_state_e state;
	spi_pkg::spi_shift_state_e state_nx;
	logic [CNT_W-1:0]          bit_cnt;
	logic [CNT_W-1:0]          bit_cnt_nx;
	logic [DATA_W-1:0]         sh;        // tx bits leave the top, rx bits enter the bottom.
	logic [DATA_W-1:0]         sh_nx;
	logic [DATA_W-1:0]         sh_shift;
	logic                      rx_bit;    // leading-edge sample for cpha=0.
	logic                      rx_bit_nx;
	logic                      mosi_nx;

	// cpha=1 samples miso right at the trailing tick.
	assign sh_shift = {sh[DATA_W-2:0], ctrl.cpha ? miso : rx_bit};
	assign rx_word  = sh_shift;   // only meaningful with rx_done.
	assign run      = (state != spi_pkg::SH_IDLE);
	assign busy     = run;

	// --------------------------------------------------------------------------
	// next state
	// --------------------------------------------------------------------------

	always_comb begin
		state_nx   = state;
		bit_cnt_nx = bit_cnt;
		sh_nx      = sh;
		rx_bit_nx  = rx_bit;
		mosi_nx    = mosi;
		tx_take    = 1'b0;
		rx_done    = 1'b0;
		if (!ctrl.en) begin
			state_nx = spi_pkg::SH_IDLE;   // abort.
			mosi_nx  = 1'b0;
		end else begin
			case (state)
				spi_pkg::SH_IDLE: begin
					tx_take = tx_valid;
				end
				spi_pkg::SH_LEAD: begin
					if (tick) begin
						state_nx = spi_pkg::SH_TRAIL;
						if (ctrl.cpha)
							mosi_nx = sh[DATA_W-1];   // drive on leading edge.
						else
							rx_bit_nx = miso;         // sample on leading edge.
					end
				end
				spi_pkg::SH_TRAIL: begin
					if (tick) begin
						sh_nx = sh_shift;
						if (bit_cnt == LAST_BIT) begin
							rx_done  = 1'b1;
							state_nx = spi_pkg::SH_IDLE;
							tx_take  = tx_valid;   // back to back, no gap.
						end else begin
							bit_cnt_nx = bit_cnt + 1'b1;
							state_nx   = spi_pkg::SH_LEAD;
							if (!ctrl.cpha)
								mosi_nx = sh[DATA_W-2];   // next bit after shift.
						end
					end
				end
				default: state_nx = spi_pkg::SH_IDLE;
			endcase
			// load, from idle or right after the last trailing edge.
			if (tx_take) begin
				state_nx   = spi_pkg::SH_LEAD;
				bit_cnt_nx = '0;
				sh_nx      = tx_word;
				// cpha=1 leaves mosi alone until the first leading edge.
				if (!ctrl.cpha)
					mosi_nx = tx_word[DATA_W-1];
			end
		end
	end

	// --------------------------------------------------------------------------
	// registers
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= spi_pkg::SH_IDLE;
			bit_cnt <= '0;
			sck     <= 1'b0;
			mosi    <= 1'b0;
		end else begin
			state   <= state_nx;
			bit_cnt <= bit_cnt_nx;
			sck     <= ctrl.cpol ^ (state_nx == spi_pkg::SH_TRAIL);   // active half.
			mosi    <= mosi_nx;
		end
	end

	always_ff @(posedge clk) begin
		sh     <= sh_nx;
		rx_bit <= rx_bit_nx;
	end

	// a word only completes out of an active transfer.
	a_no_done_idle: assert property (
		@(posedge clk) disable iff (!rst_n) rx_done |-> state != spi_pkg::SH_IDLE);

endmodule

// File: rtl/spi_master.sv
`timescale 1ns/1ps

module spi_master #(
	parameter int DATA_W = 8,   // 8 or 16.
	parameter int DIV_W  = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  spi_pkg::spi_bus_t bus,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata,
	output logic              irq,
	output logic              sck,
	output logic              mosi,
	input  logic              miso
);

	spi_pkg::spi_ctrl_t ctrl;
	logic [DATA_W-1:0]  tx_word;
	logic               tx_valid;
	logic               tx_take;
	logic [DATA_W-1:0]  rx_word;
	logic               rx_done;
	logic               busy;
	logic               run;
	logic               tick;

	// --------------------------------------------------------------------------
	// cpu side
	// --------------------------------------------------------------------------

	spi_regs #(.DATA_W(DATA_W)) regs0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (bus),
		.wdata    (wdata),
		.tx_take  (tx_take),
		.rx_done  (rx_done),
		.rx_word  (rx_word),
		.busy     (busy),
		.rdata    (rdata),
		.ctrl     (ctrl),
		.tx_word  (tx_word),
		.tx_valid (tx_valid),
		.irq      (irq)
	);

	// --------------------------------------------------------------------------
	// spi side
	// --------------------------------------------------------------------------

	spi_clkgen #(.DIV_W(DIV_W)) clkgen0 (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl),
		.run   (run),
		.tick  (tick)
	);

	spi_shifter #(.DATA_W(DATA_W)) shifter0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.tick     (tick),
		.tx_word  (tx_word),
		.tx_valid (tx_valid),
		.miso     (miso),
		.run      (run),
		.tx_take  (tx_take),
		.rx_word  (rx_word),
		.rx_done  (rx_done),
		.busy     (busy),
		.sck      (sck),
		.mosi     (mosi)
	);

endmodule

// File: verification/spi_checker.sv
`timescale 1ns/1ps

module spi_checker #(
	parameter int DATA_W = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  spi_pkg::spi_bus_t  bus,
	input  logic [DATA_W-1:0]  wdata,
	input  logic [DATA_W-1:0]  rdata,
	input  logic               irq,
	input  logic               sck,
	input  logic               mosi,
	input  logic               cap_valid,   // slave finished a word.
	input  logic [DATA_W-1:0]  cap_word,
	input  logic               rep_push,
	input  logic [DATA_W-1:0]  rep_word,
	input  logic               stat_chk,
	input  spi_pkg::spi_stat_t stat_exp,
	input  logic               lvl_chk,
	input  logic [2:0]         lvl_exp,
	input  logic [2:0]         lvl_mask,
	input  logic               test_done,
	input  int                 test_id,
	output int                 errors,
	output int                 checks
);

	spi_pkg::spi_ctrl_t ctrl_m;
	logic [DATA_W-1:0]  rx_exp;
	logic [DATA_W-1:0]  tx_q[$];    // words the slave should see.
	logic [DATA_W-1:0]  rep_q[$];   // replies not yet shifted.
	int                 t_checks, t_errors;

	initial begin
		errors   = 0;
		checks   = 0;
		t_checks = 0;
		t_errors = 0;
		ctrl_m   = '0;
		rx_exp   = '0;
	end

	function automatic string test_name(input int n);
		case (n)
			1: return "reset and idle";
			2: return "mode 0 dividers";
			3: return "cpol and cpha modes";
			4: return "status flags";
			5: return "back to back";
			default: return "irq and disable";
		endcase
	endfunction

	task automatic compare(input string name, input logic [DATA_W-1:0] e,
		input logic [DATA_W-1:0] a);
		checks++;
		t_checks++;
		if (e !== a) begin
			errors++;
			t_errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, e, a);
		end
	endtask

	// ------------------------------------------------------------------------
	// register model sampled at the rising edge
	// ------------------------------------------------------------------------

	always @(posedge clk) begin
		if (rst_n) begin
			if (bus.wr && bus.addr == spi_pkg::SPI_CTRL) begin
				ctrl_m = wdata[7:0];
				if (!ctrl_m.en) begin   // abort drops everything queued.
					tx_q.delete();
					rep_q.delete();
					rx_exp = '0;
				end
			end
			if (bus.wr && bus.addr == spi_pkg::SPI_DATA && ctrl_m.en)
				tx_q.push_back(wdata);
			if (rep_push)
				rep_q.push_back(rep_word);
			if (cap_valid) begin
				if (tx_q.size() == 0) begin
					errors++;
					t_errors++;
					$display("slave received a word at %0t that was never written", $time);
				end else begin
					compare("mosi word", tx_q.pop_front(), cap_word);
				end
				if (rep_q.size() > 0)
					rx_exp = rep_q.pop_front();   // unread word is replaced.
			end
			if (bus.rd && bus.addr == spi_pkg::SPI_CTRL)
				compare("rdata ctrl", DATA_W'(ctrl_m), rdata);
			if (bus.rd && bus.addr == spi_pkg::SPI_DATA)
				compare("rdata data", rx_exp, rdata);
			if (stat_chk)
				compare("rdata stat", DATA_W'(stat_exp), rdata);
			if (lvl_chk && lvl_mask[2])
				compare("irq", DATA_W'(lvl_exp[2]), DATA_W'(irq));
			if (lvl_chk && lvl_mask[1])
				compare("sck", DATA_W'(lvl_exp[1]), DATA_W'(sck));
			if (lvl_chk && lvl_mask[0])
				compare("mosi", DATA_W'(lvl_exp[0]), DATA_W'(mosi));
			if (test_done) begin
				$display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
					t_checks, t_errors);
				t_checks = 0;
				t_errors = 0;
			end
		end
	end

endmodule

// File: verification/spi_tb.sv
`timescale 1ns/1ps

module spi_tb;

	localparam int DATA_W = 8;
	localparam int LIMIT  = 20000;   // polls per wait.

	logic               clk;
	logic               rst_n;
	spi_pkg::spi_bus_t  bus;
	logic [DATA_W-1:0]  wdata;
	logic [DATA_W-1:0]  rdata;
	logic               irq, sck, mosi, miso;
	logic               cap_valid, rep_push, stat_chk, lvl_chk, test_done;
	logic [DATA_W-1:0]  cap_word, rep_word;
	spi_pkg::spi_stat_t stat_exp;
	logic [2:0]         lvl_exp, lvl_mask;   // irq, sck, mosi.
	int                 test_id, errors, checks, cap_count, s_bits;
	logic               s_on, s_cpol, s_cpha, s_loaded, s_sck_q, s_lead;
	logic [DATA_W-1:0]  s_rep, s_cap, d, r;
	logic [DATA_W-1:0]  s_rep_q[$];
	logic [31:0]        rng;

	spi_master #(.DATA_W(DATA_W)) dut0 (.clk(clk), .rst_n(rst_n), .bus(bus), .wdata(wdata),
		.rdata(rdata), .irq(irq), .sck(sck), .mosi(mosi), .miso(miso));

	spi_checker #(.DATA_W(DATA_W)) chk0 (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ------------------------------------------------------------------------
	// behavioral slave at the falling clock
	// ------------------------------------------------------------------------

	always @(negedge clk) begin
		cap_valid = 1'b0;
		if (s_on && sck !== s_sck_q) begin
			s_lead = (sck != s_cpol);
			if (s_lead ^ s_cpha) begin
				s_cap = {s_cap[DATA_W-2:0], mosi};   // sampling edge.
			end else if (s_cpha) begin
				miso  = s_rep[DATA_W-1];
				s_rep = s_rep << 1;
			end else begin
				s_rep = s_rep << 1;
				miso  = s_rep[DATA_W-1];
			end
			if (!s_lead) begin   // a word ends on a trailing edge.
				s_bits++;
				if (s_bits == DATA_W) begin
					cap_word  = s_cap;
					cap_valid = 1'b1;
					cap_count++;
					s_bits    = 0;
					s_loaded  = 1'b0;
				end
			end
		end
		s_sck_q = sck;
		if (s_on && !s_loaded && s_rep_q.size() > 0) begin
			s_rep    = s_rep_q.pop_front();
			s_loaded = 1'b1;
			if (!s_cpha)
				miso = s_rep[DATA_W-1];   // first bit before the leading edge.
		end
	end

	// ------------------------------------------------------------------------
	// bus tasks that start 1 ns after a rising edge
	// ------------------------------------------------------------------------

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_write(input spi_pkg::spi_addr_e a, input logic [DATA_W-1:0] v);
		bus.wr   = 1'b1;
		bus.addr = a;
		wdata    = v;
		idle(1);
		bus.wr   = 1'b0;
	endtask

	task automatic bus_read(input spi_pkg::spi_addr_e a, output logic [DATA_W-1:0] v);
		bus.rd   = 1'b1;
		bus.addr = a;
		@(negedge clk);
		v = rdata;
		idle(1);
		bus.rd   = 1'b0;
	endtask

	task automatic check_stat(input spi_pkg::spi_stat_t e);
		stat_chk = 1'b1;
		stat_exp = e;
		bus_read(spi_pkg::SPI_STAT, d);
		stat_chk = 1'b0;
	endtask

	task automatic check_pins(input logic [2:0] e, input logic [2:0] m);
		lvl_chk  = 1'b1;
		lvl_exp  = e;
		lvl_mask = m;
		idle(1);
		lvl_chk  = 1'b0;
	endtask

	task automatic wait_stat(input logic [7:0] m, input string what);
		for (int i = 0; i < LIMIT; i++) begin
			bus_read(spi_pkg::SPI_STAT, d);
			if ((d[7:0] & m) == m)
				return;
		end
		give_up(what);
	endtask

	task automatic wait_caps(input int n);
		for (int i = 0; i < LIMIT; i++) begin
			if (cap_count >= n)
				return;
			idle(1);
		end
		give_up("words at the slave");
	endtask

	task automatic push_reply(input logic [DATA_W-1:0] v);
		s_rep_q.push_back(v);
		rep_word = v;
		rep_push = 1'b1;
		idle(1);
		rep_push = 1'b0;
	endtask

	task automatic set_mode(input logic [7:0] c);
		s_on   = 1'b0;   // sck may jump to a new cpol.
		bus_write(spi_pkg::SPI_CTRL, c);
		s_cpol = c[6];
		s_cpha = c[5];
		idle(2);
		s_bits   = 0;
		s_loaded = 1'b0;
		s_rep_q.delete();
		s_on     = 1'b1;
	endtask

	task automatic transfer(input logic [DATA_W-1:0] tx, input logic [DATA_W-1:0] rx);
		push_reply(rx);
		bus_write(spi_pkg::SPI_DATA, tx);
		wait_stat(8'h40, "rxne");
		bus_read(spi_pkg::SPI_DATA, d);   // compared in the checker.
	endtask

	task automatic end_test();
		test_done = 1'b1;
		idle(1);
		test_done = 1'b0;
		test_id++;
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	initial begin
		clk       = 0;
		rst_n     = 0;
		bus       = '0;
		wdata     = '0;
		miso      = 0;
		cap_valid = 0;
		rep_push  = 0;
		stat_chk  = 0;
		lvl_chk   = 0;
		test_done = 0;
		cap_word  = '0;
		rep_word  = '0;
		stat_exp  = '0;
		lvl_exp   = '0;
		lvl_mask  = '0;
		s_on      = 0;
		s_cpol    = 0;
		s_cpha    = 0;
		s_loaded  = 0;
		s_sck_q   = 0;
		s_bits    = 0;
		s_rep     = '0;
		s_cap     = '0;
		cap_count = 0;
		test_id   = 1;
		rng       = 32'hea7d;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		idle(1);

		check_stat(8'h80);   // reset and idle.
		bus_read(spi_pkg::SPI_CTRL, d);
		check_pins(3'b000, 3'b111);
		end_test();

		for (int k = 0; k < 3; k++) begin   // mode 0 at random dividers.
			r = DATA_W'(rand32());
			set_mode({6'b100000, r[1:0]});
			for (int n = 0; n < 4; n++)
				transfer(DATA_W'(rand32()), DATA_W'(rand32()));
		end
		end_test();

		for (int m = 0; m < 4; m++) begin   // all four modes.
			r = DATA_W'(rand32());
			set_mode({1'b1, m[1], m[0], 4'b0000, r[0]});
			for (int n = 0; n < 3; n++) begin
				transfer(DATA_W'(rand32()), DATA_W'(rand32()));
				check_pins({1'b0, m[1], 1'b0}, 3'b010);
			end
		end
		end_test();

		set_mode(8'h82);   // status flags.
		push_reply(DATA_W'(rand32()));
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		check_stat(8'h00);
		wait_stat(8'h80, "txe");
		check_stat(8'ha0);
		wait_stat(8'h40, "rxne");
		check_stat(8'hc0);
		bus_read(spi_pkg::SPI_DATA, d);
		check_stat(8'h80);
		end_test();

		set_mode(8'h81);   // back to back.
		push_reply(DATA_W'(rand32()));
		push_reply(DATA_W'(rand32()));
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		wait_stat(8'h80, "txe");
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		wait_caps(cap_count + 2);
		wait_stat(8'h40, "rxne");
		bus_read(spi_pkg::SPI_DATA, d);   // second reply only.
		end_test();

		set_mode(8'h91);   // irq with ie set.
		push_reply(DATA_W'(rand32()));
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		wait_stat(8'h40, "rxne");
		check_pins(3'b100, 3'b100);
		bus_read(spi_pkg::SPI_DATA, d);
		idle(2);
		check_pins(3'b000, 3'b100);
		set_mode(8'h81);
		push_reply(DATA_W'(rand32()));
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		wait_stat(8'h40, "rxne");
		check_pins(3'b000, 3'b100);
		bus_read(spi_pkg::SPI_DATA, d);
		set_mode(8'hc3);   // abort mid word.
		push_reply(DATA_W'(rand32()));
		bus_write(spi_pkg::SPI_DATA, DATA_W'(rand32()));
		idle(40);
		s_on = 1'b0;
		bus_write(spi_pkg::SPI_CTRL, 8'h43);
		idle(2);
		check_pins(3'b010, 3'b111);
		check_stat(8'h80);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", test_id - 1, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: spi_master.f
rtl/spi_pkg.sv
rtl/spi_regs.sv
rtl/spi_clkgen.sv
rtl/spi_shifter.sv
rtl/spi_master.sv
verification/spi_checker.sv
verification/spi_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= spi_tb
RTL_TOP   ?= spi_master
FILELIST  ?= spi_master.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) rtl/spi_pkg.sv rtl/spi_regs.sv \
		rtl/spi_clkgen.sv rtl/spi_shifter.sv rtl/spi_master.sv

clean:
	rm -rf $(BUILD_DIR)
